// ==== tb.f ====
+incdir+include
logic/periph_pkg.sv
logic/periph_addr_decode.sv
logic/periph_gpio.sv
logic/periph_timer.sv
logic/periph_read_result.sv
logic/periph_top.sv
bench/periph_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the peripheral testbench with Verilator and runs it
# exit status is 0 only when the log holds the pass line

set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps \
    --top-module periph_tb -Mdir obj_dir -o periph_sim -f tb.f

./obj_dir/periph_sim > sim.log 2>&1
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see sim.log"
exit 1

// ==== bench/periph_tb.sv ====
/*
    Table driven testbench for periph_top. Builds a stimulus table with
    expected values from the bus rules, applies it entry by entry and
    checks rd, gpo, gpd or irq once per entry.
*/

`timescale 1ns/10ps

`include "periph_defines.svh"

module periph_tb
    import periph_pkg::*;
();

    localparam int CLK_PER  = 20;
    localparam int CLK_HALF = CLK_PER / 2;
    localparam int RST_CYC  = 16;
    localparam int MAX_ENT  = 80;

    // entry operations
    localparam int OP_WR    = 0;    // bus write, sampled after the write edge
    localparam int OP_RD    = 1;    // bus read, same cycle
    localparam int OP_PINS  = 2;    // drive gpi, read in the same cycle
    localparam int OP_IDLE  = 3;    // let data edges pass, then sample

    // check targets
    localparam int TGT_RD   = 0;
    localparam int TGT_GPO  = 1;
    localparam int TGT_GPD  = 2;
    localparam int TGT_IRQ  = 3;

    localparam logic [31:0] GPIO_MASK = (32'h1 << `PERIPH_GPIO_W) - 32'h1;

    logic           clk;
    logic           rst;
    bus_addr_t      addr;
    logic           we;
    bus_data_t      wd;
    bus_data_t      rd;
    gpio_t          gpi;
    gpio_t          gpo;
    gpio_t          gpd;
    logic           irq;

    // stimulus table
    int             ent_op   [MAX_ENT];
    bus_addr_t      ent_addr [MAX_ENT];
    bus_data_t      ent_data [MAX_ENT];     // write data, pin value or idle count
    bus_data_t      ent_exp  [MAX_ENT];
    int             ent_tgt  [MAX_ENT];
    string          ent_name [MAX_ENT];
    int             n_ent;
    bit             table_built;

    logic [31:0]    lfsr_state;
    int             err_cnt;
    int             tmr_m;      // edges since the enabling edge, before next entry
    int             cmp_val;    // compare value of the timer model
    int             ld_val;     // last count load
    int             ld_m;       // edge of that load

    periph_top DUT
    (
        .clk    ( clk   ),
        .rst    ( rst   ),
        .addr   ( addr  ),
        .we     ( we    ),
        .wd     ( wd    ),
        .rd     ( rd    ),
        .gpi    ( gpi   ),
        .gpo    ( gpo   ),
        .gpd    ( gpd   ),
        .irq    ( irq   )
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int b;
        v = '0;
        for (b = 0; b < n; b++)
        begin
            lfsr_state = lfsr_next(lfsr_state);    // one step per bit
            v[b]       = lfsr_state[0];
        end
    endtask

    function automatic bus_addr_t reg_addr(input blk_num_t blk, input reg_off_t off);
        reg_addr = {20'h0, blk, 4'h0, off};     // block on 11..8, offset on 3..0
    endfunction

    // count m edges after the enabling edge, restarted by a load
    function automatic int cnt_at(input int m);
        cnt_at = (ld_val + m - ld_m) % (cmp_val + 1);
    endfunction

    // first edge after 'after' that sees count == compare
    function automatic int next_wrap(input int after);
        int m;
        m = after + 1;
        while (cnt_at(m - 1) != cmp_val)
            m++;
        next_wrap = m;
    endfunction

    task automatic add_entry(input int op, input bus_addr_t a, input bus_data_t d,
                             input bus_data_t e, input int tgt, input string name);
        int pre;
        pre = (op == OP_WR) ? 1 : ((op == OP_IDLE) ? int'(d) : 0);
        ent_op[n_ent]   = op;
        ent_addr[n_ent] = a;
        ent_data[n_ent] = d;
        ent_exp[n_ent]  = e;
        ent_tgt[n_ent]  = tgt;
        ent_name[n_ent] = name;
        n_ent++;
        tmr_m += pre + 1;       // every entry ends one edge after its sample
    endtask

    // idle until edge m after enable, then sample
    task automatic add_at(input int m, input bus_addr_t a, input int tgt,
                          input int e, input string name);
        add_entry(OP_IDLE, a, m - tmr_m, e, tgt, name);
    endtask

    task automatic build_table();
        bus_addr_t      gpi_a;
        bus_addr_t      gpo_a;
        bus_addr_t      dir_a;
        bus_addr_t      en_a;
        bus_addr_t      ctl_a;
        bus_addr_t      cmp_a;
        bus_addr_t      cnt_a;
        bus_addr_t      st_a;
        logic [31:0]    pins;
        int             k;
        int             w;
        gpi_a = reg_addr(`PERIPH_BLK_GPIO, `PERIPH_GPIO_GPI);
        gpo_a = reg_addr(`PERIPH_BLK_GPIO, `PERIPH_GPIO_GPO);
        dir_a = reg_addr(`PERIPH_BLK_GPIO, `PERIPH_GPIO_DIR);
        en_a  = reg_addr(`PERIPH_BLK_GPIO, `PERIPH_GPIO_EN);
        ctl_a = reg_addr(`PERIPH_BLK_TMR, `PERIPH_TMR_CTRL);
        cmp_a = reg_addr(`PERIPH_BLK_TMR, `PERIPH_TMR_CMP);
        cnt_a = reg_addr(`PERIPH_BLK_TMR, `PERIPH_TMR_CNT);
        st_a  = reg_addr(`PERIPH_BLK_TMR, `PERIPH_TMR_STAT);

        // reset state
        add_entry(OP_RD, gpo_a, 0, 0, TGT_GPO, "reset gpo low");
        add_entry(OP_RD, gpo_a, 0, 0, TGT_GPD, "reset gpd low");
        add_entry(OP_RD, gpo_a, 0, 0, TGT_IRQ, "reset irq low");
        take_bits(`PERIPH_GPIO_W, pins);
        add_entry(OP_PINS, gpi_a, pins, pins, TGT_RD, "reset gpi follows pins");
        add_entry(OP_RD, gpo_a, 0, 0, TGT_RD, "reset gpo reg");
        add_entry(OP_RD, dir_a, 0, 0, TGT_RD, "reset dir reg");
        add_entry(OP_RD, en_a, 0, 0, TGT_RD, "reset en reg");
        add_entry(OP_RD, ctl_a, 0, 0, TGT_RD, "reset timer ctrl");
        add_entry(OP_RD, cmp_a, 0, 0, TGT_RD, "reset timer cmp");
        add_entry(OP_RD, cnt_a, 0, 0, TGT_RD, "reset timer cnt");
        add_entry(OP_RD, st_a, 0, 0, TGT_RD, "reset timer status");
        add_entry(OP_IDLE, cnt_a, 3, 0, TGT_RD, "timer idle after reset");

        // gpio enable gate
        add_entry(OP_WR, gpo_a, 32'hFF, 0, TGT_GPO, "gpo write while disabled");
        add_entry(OP_WR, dir_a, 32'hFF, 0, TGT_GPD, "dir write while disabled");
        add_entry(OP_WR, en_a, 32'hFFFF_FFFF, 1, TGT_RD, "enable readback one bit");
        add_entry(OP_WR, gpo_a, 32'h1234_56C3, 32'h1234_56C3 & GPIO_MASK, TGT_GPO,
                  "gpo write while enabled");
        add_entry(OP_RD, gpo_a, 0, 32'h1234_56C3 & GPIO_MASK, TGT_RD, "gpo readback");
        add_entry(OP_WR, dir_a, 32'hABCD_EF5A, 32'hABCD_EF5A & GPIO_MASK, TGT_GPD,
                  "dir write while enabled");
        add_entry(OP_RD, dir_a, 0, 32'hABCD_EF5A & GPIO_MASK, TGT_RD, "dir readback");
        add_entry(OP_WR, en_a, 32'h2, 0, TGT_RD, "enable takes bit 0 only");
        add_entry(OP_WR, gpo_a, 32'h3C, 32'h1234_56C3 & GPIO_MASK, TGT_GPO,
                  "gpo gated again");
        add_entry(OP_WR, en_a, 32'h1, 1, TGT_RD, "enable again");

        // pin input, raw and zero extended
        for (k = 0; k < 4; k++)
        begin
            take_bits(`PERIPH_GPIO_W, pins);
            add_entry(OP_PINS, gpi_a, pins, pins, TGT_RD, "gpi read of lfsr pins");
        end
        add_entry(OP_RD, reg_addr(`PERIPH_BLK_GPIO, 4'h7), 0, pins, TGT_RD,
                  "unknown gpio offset reads pins");

        // decode
        add_entry(OP_WR, reg_addr(4'h2, `PERIPH_GPIO_GPO), 32'hFF,
                  32'h1234_56C3 & GPIO_MASK, TGT_GPO, "unmapped write ignored");
        add_entry(OP_WR, reg_addr(4'hF, `PERIPH_TMR_CTRL), 32'h1, 0, TGT_RD,
                  "unmapped read after write");
        add_entry(OP_RD, ctl_a, 0, 0, TGT_RD, "timer ctrl untouched");
        add_entry(OP_RD, reg_addr(4'h2, `PERIPH_GPIO_GPI), 0, 0, TGT_RD,
                  "unmapped gpi slot reads zero");
        add_entry(OP_WR, cmp_a, 32'h0000_1234, 32'h1234, TGT_RD, "timer cmp readback");
        add_entry(OP_RD, reg_addr(`PERIPH_BLK_TMR, 4'h7), 0, 0, TGT_RD,
                  "unknown timer offset reads zero");   // cmp is nonzero here
        add_entry(OP_RD, gpo_a, 0, 32'h1234_56C3 & GPIO_MASK, TGT_RD,
                  "gpo untouched by timer write");
        add_entry(OP_WR, dir_a, 32'h96, 32'h96, TGT_GPD, "dir write at offset 2");
        add_entry(OP_RD, cnt_a, 0, 0, TGT_RD, "timer cnt untouched by gpio");

        // timer count and wrap
        cmp_val = 5;
        add_entry(OP_WR, cmp_a, cmp_val, cmp_val, TGT_RD, "timer cmp set");
        tmr_m  = -1;                // next edge enables, m = 0
        ld_val = 0;
        ld_m   = 0;
        add_entry(OP_WR, ctl_a, 1, 1, TGT_RD, "timer enable");
        add_at(3, cnt_a, TGT_RD, cnt_at(3), "count before wrap");
        add_at(cmp_val, cnt_a, TGT_IRQ, 0, "irq low up to compare");
        add_at(cmp_val + 1, cnt_a, TGT_IRQ, 1, "irq set on wrap");
        // offset 3 of block 0 must not reach the status register
        add_entry(OP_WR, en_a, 32'h1, 1, TGT_IRQ, "gpio en write leaves irq set");
        add_at(9, cnt_a, TGT_RD, cnt_at(9), "count after wrap");
        add_at(14, cnt_a, TGT_RD, cnt_at(14), "count after two wraps");

        // count load, upper bits dropped
        ld_m   = tmr_m + 1;
        ld_val = 2;
        add_entry(OP_WR, cnt_a, 32'hABCD_0002, ld_val, TGT_RD, "count load");
        add_at(tmr_m + 2, cnt_a, TGT_RD, cnt_at(tmr_m + 2), "count from loaded value");

        // flag clear and set again
        k = tmr_m + 1;                              // edge of the status write
        add_entry(OP_WR, st_a, 32'hFFFF_FFFE, 0, TGT_IRQ, "status write clears irq");
        add_entry(OP_RD, en_a, 0, 1, TGT_RD, "status write leaves gpio en");
        w = next_wrap(k);
        add_at(w - 1, cnt_a, TGT_IRQ, 0, "irq stays clear before wrap");
        add_at(w, cnt_a, TGT_IRQ, 1, "irq set again on next wrap");
        add_at(tmr_m, st_a, TGT_RD, 1, "status flag readback");

        // status write landing on a wrap edge
        w = next_wrap(tmr_m);
        add_at(w - 2, cnt_a, TGT_RD, cnt_at(w - 2), "count before wrap edge");
        add_entry(OP_WR, st_a, 32'h0, 0, TGT_IRQ, "clear beats same edge match");
    endtask

    task automatic compare_value(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act, output bit ok);
        ok = (act === exp);
        if (!ok)
        begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, sig, exp, act);
            err_cnt++;
        end
    endtask

    // watchdog, sized from the table length
    initial
    begin
        wait (table_built);
        #(((n_ent * 40) + RST_CYC) * CLK_PER);
        $display("watchdog: run timed out after %0d cycles", (n_ent * 40) + RST_CYC);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        int     i;
        bit     ok;
        int     n_pass;
        rst         = 1'b1;
        addr        = '0;
        we          = 1'b0;
        wd          = '0;
        gpi         = '0;
        n_ent       = 0;
        err_cnt     = 0;
        n_pass      = 0;
        tmr_m       = 0;
        cmp_val     = 0;
        ld_val      = 0;
        ld_m        = 0;
        lfsr_state  = 32'hc9d5_e4fc;
        table_built = 1'b0;
        build_table();
        table_built = 1'b1;

        repeat (RST_CYC) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // each entry starts on a falling edge
        for (i = 0; i < n_ent; i++)
        begin
            addr = ent_addr[i];
            we   = (ent_op[i] == OP_WR);
            wd   = (ent_op[i] == OP_WR) ? ent_data[i] : '0;
            if (ent_op[i] == OP_PINS)
                gpi = ent_data[i][`PERIPH_GPIO_W-1 : 0];
            if (ent_op[i] == OP_WR)
            begin
                @(negedge clk);         // write stored at the edge in between
                we = 1'b0;
                wd = '0;
            end
            else if (ent_op[i] == OP_IDLE)
                repeat (ent_data[i]) @(negedge clk);
            #(CLK_HALF - 2);            // sample just before the rising edge
            case (ent_tgt[i])
                TGT_RD  : compare_value("rd", ent_exp[i], rd, ok);
                TGT_GPO : compare_value("gpo", ent_exp[i], 32'(gpo), ok);
                TGT_GPD : compare_value("gpd", ent_exp[i], 32'(gpd), ok);
                default : compare_value("irq", ent_exp[i], 32'(irq), ok);
            endcase
            if (ok)
                n_pass++;
            $display("test %0d %0s: %0s", i, ent_name[i], ok ? "ok" : "mismatch");
            @(negedge clk);
        end

        $display("tests %0d, passed %0d, failed %0d", n_ent, n_pass, n_ent - n_pass);
        if (err_cnt == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule : periph_tb

// ==== logic/periph_top.sv ====
/*
    Peripheral subsystem top. Bus address, strobe and write data go
    through the decoder to the GPIO and timer blocks, and the result
    stage picks the read word. Pins and irq leave at this level.
*/

`timescale 1ns/10ps

module periph_top
(
    // clock and reset
    input   logic                   clk,    // system clock
    input   logic                   rst,    // sync reset, active high
    // bus side
    input   periph_pkg::bus_addr_t  addr,   // address
    input   logic                   we,     // write strobe
    input   periph_pkg::bus_data_t  wd,     // write data
    output  periph_pkg::bus_data_t  rd,     // read data, same cycle
    // pins and interrupt
    input   periph_pkg::gpio_t      gpi,    // gpio inputs
    output  periph_pkg::gpio_t      gpo,    // gpio outputs
    output  periph_pkg::gpio_t      gpd,    // gpio direction
    output  logic                   irq     // timer match
);

    logic                   gpio_we;    // strobe into gpio
    logic                   tmr_we;     // strobe into timer
    periph_pkg::blk_num_t   rd_sel;     // block selected for read
    logic                   rd_hit;     // mapped address
    periph_pkg::bus_data_t  gpio_rd;    // gpio readback
    periph_pkg::bus_data_t  tmr_rd;     // timer readback

    // decode
    periph_addr_decode u_decode
    (
        .addr       ( addr          ),
        .we         ( we            ),
        .gpio_we    ( gpio_we       ),
        .tmr_we     ( tmr_we        ),
        .rd_sel     ( rd_sel        ),
        .rd_hit     ( rd_hit        )
    );

    // block 0
    periph_gpio u_gpio
    (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .off        ( addr[3 : 0]   ),  // offset bits only
        .we         ( gpio_we       ),
        .wd         ( wd            ),
        .rd         ( gpio_rd       ),
        .gpi        ( gpi           ),
        .gpo        ( gpo           ),
        .gpd        ( gpd           )
    );

    // block 1
    periph_timer u_timer
    (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .off        ( addr[3 : 0]   ),
        .we         ( tmr_we        ),
        .wd         ( wd            ),
        .rd         ( tmr_rd        ),
        .irq        ( irq           )
    );

    // read result
    periph_read_result u_result
    (
        .rd_sel     ( rd_sel        ),
        .rd_hit     ( rd_hit        ),
        .gpio_rd    ( gpio_rd       ),
        .tmr_rd     ( tmr_rd        ),
        .rd         ( rd            )
    );

endmodule : periph_top

// ==== logic/periph_read_result.sv ====
/*
    Read data selector. Returns the word of the block named by the
    decoder, or zero for an unmapped address. New blocks get a case
    entry here and a compare in the decoder.
*/

`timescale 1ns/10ps

`include "periph_defines.svh"

module periph_read_result
    import periph_pkg::*;
(
    input   blk_num_t       rd_sel,     // addressed block
    input   logic           rd_hit,     // block is mapped
    input   bus_data_t      gpio_rd,    // gpio read word
    input   bus_data_t      tmr_rd,     // timer read word
    output  bus_data_t      rd          // bus read data
);

    always_comb
    begin
        rd = '0;                            // unmapped reads as zero
        if( rd_hit )
        begin
            case( rd_sel )
                `PERIPH_BLK_GPIO : rd = gpio_rd;
                `PERIPH_BLK_TMR  : rd = tmr_rd;
                default          : rd = '0;
            endcase
        end
    end

endmodule : periph_read_result

// ==== logic/periph_timer.sv ====
/*
    Compare timer on block 1. Counts clock cycles while enabled, wraps to
    zero when the count equals the compare value and sets a sticky flag
    that drives irq. Any write to the status register clears the flag.
*/

`timescale 1ns/10ps

`include "periph_defines.svh"

module periph_timer
    import periph_pkg::*;
(
    // clock and reset
    input   logic           clk,    // system clock
    input   logic           rst,    // sync reset, active high
    // bus side
    input   reg_off_t       off,    // register offset
    input   logic           we,     // block write strobe
    input   bus_data_t      wd,     // write data
    output  bus_data_t      rd,     // read data, combinational
    // interrupt
    output  logic           irq     // match flag
);

    logic       tmr_en;     // counting enabled
    tmr_cnt_t   tmr_cmp;    // compare value
    tmr_cnt_t   tmr_cnt;    // current count
    logic       tmr_flag;   // sticky match
    logic       ctrl_we;
    logic       cmp_we;
    logic       cnt_we;
    logic       stat_we;
    logic       match;      // count hits compare this cycle

    // register strobes
    assign ctrl_we = we && ( off == `PERIPH_TMR_CTRL );
    assign cmp_we  = we && ( off == `PERIPH_TMR_CMP  );
    assign cnt_we  = we && ( off == `PERIPH_TMR_CNT  );
    assign stat_we = we && ( off == `PERIPH_TMR_STAT );

    assign match = tmr_en && ( tmr_cnt == tmr_cmp );

    // control and compare
    always_ff @(posedge clk)
    begin
        if( rst )
        begin
            tmr_en  <= 1'b0;
            tmr_cmp <= '0;
        end
        else
        begin
            if( ctrl_we )
                tmr_en <= wd[0];
            if( cmp_we )
                tmr_cmp <= wd[15 : 0];
        end
    end

    // counter, a bus write replaces the step
    always_ff @(posedge clk)
    begin
        if( rst )
            tmr_cnt <= '0;
        else if( cnt_we )
            tmr_cnt <= wd[15 : 0];
        else if( match )
            tmr_cnt <= '0;                          // wrap
        else if( tmr_en )
            tmr_cnt <= tmr_cnt + tmr_cnt_t'(1);
    end

    // sticky flag, clear beats a same cycle match
    always_ff @(posedge clk)
    begin
        if( rst )
            tmr_flag <= 1'b0;
        else if( stat_we )
            tmr_flag <= 1'b0;
        else if( match )
            tmr_flag <= 1'b1;
    end

    assign irq = tmr_flag;

    // register readback, zero extended
    always_comb
    begin
        rd = '0;
        case( off )
            `PERIPH_TMR_CTRL : rd[0]       = tmr_en;
            `PERIPH_TMR_CMP  : rd[15 : 0]  = tmr_cmp;
            `PERIPH_TMR_CNT  : rd[15 : 0]  = tmr_cnt;
            `PERIPH_TMR_STAT : rd[0]       = tmr_flag;
            default          : rd          = '0;
        endcase
    end

endmodule : periph_timer

// ==== logic/periph_gpio.sv ====
/*
    GPIO block: output, direction and enable registers plus a raw pin
    input read path. Output and direction accept writes only while the
    enable bit is set. Sits behind the address decoder on block 0.
*/

`timescale 1ns/10ps

`include "periph_defines.svh"

module periph_gpio
    import periph_pkg::*;
(
    // clock and reset
    input   logic           clk,    // system clock
    input   logic           rst,    // sync reset, active high
    // bus side
    input   reg_off_t       off,    // register offset
    input   logic           we,     // block write strobe
    input   bus_data_t      wd,     // write data
    output  bus_data_t      rd,     // read data, combinational
    // pin side
    input   gpio_t          gpi,    // raw pin inputs
    output  gpio_t          gpo,    // output values
    output  gpio_t          gpd     // direction, 1 drives the pin
);

    gpio_t      gpio_o;         // output register
    gpio_t      gpio_d;         // direction register
    logic       gpio_en;        // block enable
    logic       gpo_we;         // output write
    logic       gpd_we;         // direction write
    logic       gpio_en_we;     // enable write, not gated by enable

    // per register strobes
    assign gpo_we     = we && ( off == `PERIPH_GPIO_GPO ) && gpio_en;
    assign gpd_we     = we && ( off == `PERIPH_GPIO_DIR ) && gpio_en;
    assign gpio_en_we = we && ( off == `PERIPH_GPIO_EN  );

    // output register
    always_ff @(posedge clk)
    begin
        if( rst )
            gpio_o <= '0;
        else if( gpo_we )
            gpio_o <= wd[`PERIPH_GPIO_W-1 : 0];
    end

    // direction register
    always_ff @(posedge clk)
    begin
        if( rst )
            gpio_d <= '0;
        else if( gpd_we )
            gpio_d <= wd[`PERIPH_GPIO_W-1 : 0];
    end

    // enable bit
    always_ff @(posedge clk)
    begin
        if( rst )
            gpio_en <= 1'b0;
        else if( gpio_en_we )
            gpio_en <= wd[0];
    end

    assign gpo = gpio_o;
    assign gpd = gpio_d;

    // local read mux, zero extended
    always_comb
    begin
        rd = '0;
        case( off )
            `PERIPH_GPIO_GPI : rd[`PERIPH_GPIO_W-1 : 0] = gpi;
            `PERIPH_GPIO_GPO : rd[`PERIPH_GPIO_W-1 : 0] = gpio_o;
            `PERIPH_GPIO_DIR : rd[`PERIPH_GPIO_W-1 : 0] = gpio_d;
            `PERIPH_GPIO_EN  : rd[0]                    = gpio_en;
            default          : rd[`PERIPH_GPIO_W-1 : 0] = gpi;  // unknown reads pins
        endcase
    end

endmodule : periph_gpio

// ==== logic/periph_addr_decode.sv ====
/*
    Address decode for the peripheral bus. Splits the bus write strobe
    into one strobe per block and tells the read result stage which block
    answers, or that nothing is mapped at this address.
*/

`timescale 1ns/10ps

`include "periph_defines.svh"

module periph_addr_decode
    import periph_pkg::*;
(
    input   bus_addr_t      addr,       // bus address
    input   logic           we,         // bus write strobe
    output  logic           gpio_we,    // write strobe for block 0
    output  logic           tmr_we,     // write strobe for block 1
    output  blk_num_t       rd_sel,     // addressed block when mapped
    output  logic           rd_hit      // some block is mapped here
);

    blk_num_t   blk;        // block field of the address
    logic       hit_gpio;   // address falls in gpio block
    logic       hit_tmr;    // address falls in timer block

    assign blk = addr[11 : 8];

    // compare against the mapped block numbers
    assign hit_gpio = ( blk == `PERIPH_BLK_GPIO );
    assign hit_tmr  = ( blk == `PERIPH_BLK_TMR  );

    // unmapped writes reach no block
    assign gpio_we = we && hit_gpio;
    assign tmr_we  = we && hit_tmr;

    // read side
    assign rd_hit = hit_gpio || hit_tmr;
    assign rd_sel = rd_hit ? blk : '0;  // parked at 0 when unmapped

endmodule : periph_addr_decode

// ==== logic/periph_pkg.sv ====
/*
    Types shared by the peripheral blocks and the top level.
    Modules pull these in by importing the package in their header.
*/

`include "periph_defines.svh"

package periph_pkg;

    // bus side
    typedef logic [31 : 0]                  bus_addr_t;     // byte address
    typedef logic [31 : 0]                  bus_data_t;     // write / read word

    // address fields
    typedef logic [3 : 0]                   reg_off_t;      // addr[3:0]
    typedef logic [3 : 0]                   blk_num_t;      // addr[11:8]

    // gpio pins
    typedef logic [`PERIPH_GPIO_W-1 : 0]    gpio_t;

    // timer count and compare
    typedef logic [15 : 0]                  tmr_cnt_t;

endpackage : periph_pkg

// ==== include/periph_defines.svh ====
/*
    Shared constants for the peripheral subsystem: GPIO width, block
    numbers on address bits 11..8 and register offsets on bits 3..0.
    Include wherever a block number or an offset is compared.
*/

`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// gpio pin count
`define PERIPH_GPIO_W       8

// block numbers, matched against addr[11:8]
`define PERIPH_BLK_GPIO     4'h0
`define PERIPH_BLK_TMR      4'h1

// gpio register offsets
`define PERIPH_GPIO_GPI     4'h0    // pin inputs, read only
`define PERIPH_GPIO_GPO     4'h1    // output register
`define PERIPH_GPIO_DIR     4'h2    // direction register
`define PERIPH_GPIO_EN      4'h3    // block enable, bit 0

// timer register offsets
`define PERIPH_TMR_CTRL     4'h0    // bit 0 enables counting
`define PERIPH_TMR_CMP      4'h1    // compare value
`define PERIPH_TMR_CNT      4'h2    // live count, writable
`define PERIPH_TMR_STAT     4'h3    // sticky match flag, any write clears

`endif
